//--- rtl/xt_io_pkg.sv
// Shared bus, chip select and EMS types for the XT I/O glue block
// Also holds the fixed port addresses and the EMS write codes
// Imported by the RTL modules and by the testbench

package xt_io_pkg;

    // One sample of the system bus, all strobes active low
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  wdata;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        address_enable_n;
    } io_bus_t;

    // Active-low selects for the chips outside the block
    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
    } chip_select_t;

    // Hits on registers held inside the block, active high
    typedef struct packed {
        logic ems;
        logic lpt;
        logic nmi_mask;
    } io_hit_t;

    // Base segment of the four 16 KB EMS windows
    typedef enum logic [1:0] {
        SEG_A000 = 2'd0,
        SEG_C000 = 2'd1,
        SEG_D000 = 2'd2
    } ems_segment_e;

    typedef struct packed {
        logic [6:0] page;
        logic       enable;
    } ems_entry_t;

    // Map entries, one per memory window
    localparam int EMS_ENTRIES = 4;

    // Tandy NMI mask ports 0xA0..0xA7
    localparam logic [15:0] NMI_MASK_BASE = 16'h00A0;

    // Port bases used unless the top level overrides them
    localparam logic [15:0] DEFAULT_EMS_IO_BASE = 16'h0260;
    localparam logic [15:0] DEFAULT_LPT_IO_BASE = 16'h0378;

    // Writing this byte turns an entry off
    localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;

    // Bytes below this are page numbers
    localparam logic [7:0] EMS_PAGE_LIMIT = 8'h80;

endpackage

//--- rtl/io_decoder.sv
// I/O address decode of the XT glue block
// Produces the external chip selects of the low I/O page and the
// hits on the internal EMS, printer and NMI mask registers

`timescale 1ns/1ps

module io_decoder #(
    parameter logic [15:0] EMS_IO_BASE = xt_io_pkg::DEFAULT_EMS_IO_BASE,
    parameter logic [15:0] LPT_IO_BASE = xt_io_pkg::DEFAULT_LPT_IO_BASE
) (
    input  xt_io_pkg::io_bus_t      bus_i,
    input  logic                    tandy_video_i,
    input  logic                    ems_enabled_i,
    output xt_io_pkg::chip_select_t chip_select_o,
    output xt_io_pkg::io_hit_t      hit_o
);

    import xt_io_pkg::*;

    logic         iorq;
    logic         io_cycle;
    logic         low_page;
    logic [15:0]  io_address;
    chip_select_t select_n;

    assign iorq       = !bus_i.io_read_n || !bus_i.io_write_n;
    assign io_cycle   = iorq && !bus_i.address_enable_n;
    assign io_address = bus_i.address[15:0];

    // Ports 0x000..0x0FF belong to the motherboard chips
    assign low_page = io_cycle && (bus_i.address[9:8] == 2'b00);

    // One select per 32-port block, codes 5..7 are unused
    always_comb begin
        select_n = '1;
        if (low_page) begin
            case (bus_i.address[7:5])
                3'd0: begin
                    select_n.dma_n = 1'b0;
                end
                3'd1: begin
                    select_n.pic_n = 1'b0;
                end
                3'd2: begin
                    select_n.pit_n = 1'b0;
                end
                3'd3: begin
                    select_n.ppi_n = 1'b0;
                end
                3'd4: begin
                    select_n.dma_page_n = 1'b0;
                end
                default: begin
                    select_n = '1;
                end
            endcase
        end
    end

    assign chip_select_o = select_n;

    // EMS map covers four ports from the base
    assign hit_o.ems = io_cycle && ems_enabled_i
        && (io_address[15:2] == EMS_IO_BASE[15:2]);

    assign hit_o.lpt = io_cycle && (io_address == LPT_IO_BASE);

    // NMI mask only exists on Tandy machines
    assign hit_o.nmi_mask = io_cycle && tandy_video_i
        && (io_address[15:3] == NMI_MASK_BASE[15:3]);

endmodule

//--- rtl/ems_mapper.sv
// EMS page map register bank and memory window decode
// Port writes go through one pipeline stage before the entry changes,
// the window hits follow the entries combinationally

`timescale 1ns/1ps

module ems_mapper (
    input  logic                  clock,
    input  logic                  reset,
    input  xt_io_pkg::io_bus_t    bus_i,
    input  logic                  ems_hit_i,
    input  logic [1:0]            ems_address_i,
    output xt_io_pkg::ems_entry_t entry_o [xt_io_pkg::EMS_ENTRIES],
    output logic [xt_io_pkg::EMS_ENTRIES-1:0] ems_window_o
);

    import xt_io_pkg::*;

    logic         iorq;
    logic         wr_valid;
    ems_entry_t   wr_value;
    logic         wr_strobe_q;
    logic [1:0]   wr_index_q;
    ems_entry_t   wr_entry_q;
    ems_segment_e segment;
    logic [3:0]   seg_nibble;

    assign iorq = !bus_i.io_read_n || !bus_i.io_write_n;

    // 0xFF disables, a page number enables, anything else is ignored
    always_comb begin
        wr_valid = 1'b1;
        wr_value = '0;
        if (bus_i.wdata == EMS_DISABLE_CODE) begin
            wr_value.page   = EMS_DISABLE_CODE[6:0];
            wr_value.enable = 1'b0;
        end else if (bus_i.wdata < EMS_PAGE_LIMIT) begin
            wr_value.page   = bus_i.wdata[6:0];
            wr_value.enable = 1'b1;
        end else begin
            wr_valid = 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_strobe_q <= 1'b0;
        end else begin
            wr_strobe_q <= ems_hit_i && !bus_i.io_write_n && wr_valid;
        end
    end

    always_ff @(posedge clock) begin
        wr_index_q <= bus_i.address[1:0];
        wr_entry_q <= wr_value;
    end

    // Entry update one edge after the write was seen
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_ENTRIES; i++) begin
                entry_o[i] <= '0;
            end
        end else if (wr_strobe_q) begin
            entry_o[wr_index_q] <= wr_entry_q;
        end
    end

    always_comb begin
        case (ems_address_i)
            2'd0:    segment = SEG_A000;
            2'd1:    segment = SEG_C000;
            default: segment = SEG_D000;
        endcase
    end

    // Upper address nibble of the window base
    always_comb begin
        case (segment)
            SEG_A000: seg_nibble = 4'hA;
            SEG_C000: seg_nibble = 4'hC;
            default:  seg_nibble = 4'hD;
        endcase
    end

    // Window k spans 16 KB at segment + k * 0x400
    for (genvar k = 0; k < EMS_ENTRIES; k++) begin : g_window
        assign ems_window_o[k] = entry_o[k].enable && !iorq
            && (bus_i.address[19:14] == {seg_nibble, 2'(k)});
    end

endmodule

//--- rtl/io_byte_regs.sv
// Printer data latch and Tandy NMI mask register
// Each byte is loaded from the bus on an I/O write that hits it
// and is visible from the next cycle on

`timescale 1ns/1ps

module io_byte_regs (
    input  logic               clock,
    input  logic               reset,
    input  xt_io_pkg::io_bus_t bus_i,
    input  logic               lpt_hit_i,
    input  logic               nmi_hit_i,
    output logic [7:0]         lpt_data_o,
    output logic [7:0]         nmi_mask_o
);

    logic lpt_write;
    logic nmi_write;

    assign lpt_write = lpt_hit_i && !bus_i.io_write_n;
    assign nmi_write = nmi_hit_i && !bus_i.io_write_n;

    // Printer data port, idles high like the real latch
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_o <= 8'hFF;
        end else if (lpt_write) begin
            lpt_data_o <= bus_i.wdata;
        end
    end

    // NMI mask starts with every bit set
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nmi_mask_o <= 8'hFF;
        end else if (nmi_write) begin
            nmi_mask_o <= bus_i.wdata;
        end
    end

endmodule

//--- rtl/read_back_mux.sv
// Registered read-back of the chipset's own registers
// Picks the highest priority hit in an I/O read and drives its data
// with the chipset flag on the following cycle

`timescale 1ns/1ps

module read_back_mux (
    input  logic                  clock,
    input  logic                  reset,
    input  xt_io_pkg::io_bus_t    bus_i,
    input  xt_io_pkg::io_hit_t    hit_i,
    input  xt_io_pkg::ems_entry_t entry_i [xt_io_pkg::EMS_ENTRIES],
    input  logic [7:0]            lpt_data_i,
    input  logic [7:0]            nmi_mask_i,
    output logic [7:0]            data_bus_out_o,
    output logic                  data_from_chipset_o
);

    import xt_io_pkg::*;

    logic       io_read;
    ems_entry_t ems_entry;
    logic [7:0] ems_data;

    assign io_read = !bus_i.io_read_n;

    // Disabled entries read back as 0xFF
    assign ems_entry = entry_i[bus_i.address[1:0]];
    assign ems_data  = ems_entry.enable ? {1'b0, ems_entry.page} : 8'hFF;

    // EMS first, then printer, then NMI mask
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_from_chipset_o <= 1'b0;
            data_bus_out_o      <= 8'h00;
        end else if (io_read && hit_i.ems) begin
            data_from_chipset_o <= 1'b1;
            data_bus_out_o      <= ems_data;
        end else if (io_read && hit_i.lpt) begin
            data_from_chipset_o <= 1'b1;
            data_bus_out_o      <= lpt_data_i;
        end else if (io_read && hit_i.nmi_mask) begin
            data_from_chipset_o <= 1'b1;
            data_bus_out_o      <= nmi_mask_i;
        end else begin
            data_from_chipset_o <= 1'b0;
            data_bus_out_o      <= 8'h00;
        end
    end

endmodule

//--- rtl/xt_io_top.sv
// Top of the XT I/O glue block
// Packs the system bus into one struct and connects the decoder,
// the EMS map, the byte registers and the read-back path

`timescale 1ns/1ps

module xt_io_top #(
    parameter logic [15:0] EMS_IO_BASE = xt_io_pkg::DEFAULT_EMS_IO_BASE,
    parameter logic [15:0] LPT_IO_BASE = xt_io_pkg::DEFAULT_LPT_IO_BASE
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [19:0]             address_i,
    input  logic [7:0]              data_i,
    input  logic                    io_read_n_i,
    input  logic                    io_write_n_i,
    input  logic                    memory_read_n_i,
    input  logic                    address_enable_n_i,
    input  logic                    tandy_video_i,
    input  logic                    ems_enabled_i,
    input  logic [1:0]              ems_address_i,
    output xt_io_pkg::chip_select_t chip_select_o,
    output logic [xt_io_pkg::EMS_ENTRIES-1:0] ems_window_o,
    output logic [7:0]              data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);

    import xt_io_pkg::*;

    io_bus_t    bus;
    io_hit_t    hit;
    ems_entry_t ems_entry [EMS_ENTRIES];
    logic [7:0] lpt_data;
    logic [7:0] nmi_mask;

    assign bus.address          = address_i;
    assign bus.wdata            = data_i;
    assign bus.io_read_n        = io_read_n_i;
    assign bus.io_write_n       = io_write_n_i;
    assign bus.memory_read_n    = memory_read_n_i;
    assign bus.address_enable_n = address_enable_n_i;

    io_decoder #(
        .EMS_IO_BASE (EMS_IO_BASE),
        .LPT_IO_BASE (LPT_IO_BASE)
    ) u_io_decoder (
        .bus_i         (bus),
        .tandy_video_i (tandy_video_i),
        .ems_enabled_i (ems_enabled_i),
        .chip_select_o (chip_select_o),
        .hit_o         (hit)
    );

    ems_mapper u_ems_mapper (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (bus),
        .ems_hit_i     (hit.ems),
        .ems_address_i (ems_address_i),
        .entry_o       (ems_entry),
        .ems_window_o  (ems_window_o)
    );

    io_byte_regs u_io_byte_regs (
        .clock      (clock),
        .reset      (reset),
        .bus_i      (bus),
        .lpt_hit_i  (hit.lpt),
        .nmi_hit_i  (hit.nmi_mask),
        .lpt_data_o (lpt_data),
        .nmi_mask_o (nmi_mask)
    );

    read_back_mux u_read_back_mux (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus),
        .hit_i               (hit),
        .entry_i             (ems_entry),
        .lpt_data_i          (lpt_data),
        .nmi_mask_i          (nmi_mask),
        .data_bus_out_o      (data_bus_out_o),
        .data_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

//--- tb/io_checker.sv
// Reference model and output comparison for the XT I/O glue block
// Watches the bus and the DUT outputs, models the registers on the
// rising edge and compares every output on the falling edge

`timescale 1ns/1ps

module io_checker #(
    parameter logic [15:0] EMS_IO_BASE = xt_io_pkg::DEFAULT_EMS_IO_BASE,
    parameter logic [15:0] LPT_IO_BASE = xt_io_pkg::DEFAULT_LPT_IO_BASE
) (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_io_pkg::io_bus_t      bus_i,
    input  logic                    tandy_video_i,
    input  logic                    ems_enabled_i,
    input  logic [1:0]              ems_address_i,
    input  xt_io_pkg::chip_select_t chip_select_i,
    input  logic [3:0]              ems_window_i,
    input  logic [7:0]              data_bus_out_i,
    input  logic                    data_from_chipset_i,
    output int                      error_count_o,
    output int                      check_count_o,
    output int                      read_count_o
);

    import xt_io_pkg::*;

    int           errors = 0;
    int           checks = 0;
    int           reads = 0;
    logic [6:0]   page_q [4];
    logic [3:0]   enable_q;
    logic         pend_valid_q;
    logic [1:0]   pend_index_q;
    logic [6:0]   pend_page_q;
    logic         pend_enable_q;
    logic [7:0]   lpt_q;
    logic [7:0]   nmi_q;
    logic         read_flag_q;
    logic [7:0]   read_data_q;
    logic         iorq;
    logic         io_cycle;
    logic         ems_hit;
    logic         lpt_hit;
    logic         nmi_hit;
    logic [7:0]   read_value;
    logic [3:0]   nibble;
    chip_select_t exp_select;
    logic [3:0]   exp_window;

    assign error_count_o = errors;
    assign check_count_o = checks;
    assign read_count_o  = reads;

    assign iorq     = !bus_i.io_read_n || !bus_i.io_write_n;
    assign io_cycle = iorq && !bus_i.address_enable_n;
    assign ems_hit  = io_cycle && ems_enabled_i
        && (bus_i.address[15:2] == EMS_IO_BASE[15:2]);
    assign lpt_hit  = io_cycle && (bus_i.address[15:0] == LPT_IO_BASE);
    assign nmi_hit  = io_cycle && tandy_video_i
        && (bus_i.address[15:3] == NMI_MASK_BASE[15:3]);

    // Code 0 selects the DMA controller and each higher code the next chip
    assign exp_select = (io_cycle && bus_i.address[9:8] == 2'b00)
        ? ~(5'b10000 >> bus_i.address[7:5]) : 5'b11111;

    // Address bits 15..14 pick the window inside the selected segment
    always_comb begin
        case (ems_address_i)
            2'd0:    nibble = 4'hA;
            2'd1:    nibble = 4'hC;
            default: nibble = 4'hD;
        endcase
        exp_window = 4'h0;
        if (!iorq && bus_i.address[19:16] == nibble) begin
            exp_window = enable_q & (4'b0001 << bus_i.address[15:14]);
        end
    end

    // Priority ems, lpt, nmi mask
    always_comb begin
        read_value = 8'h00;
        if (!bus_i.io_read_n) begin
            if (ems_hit) begin
                read_value = enable_q[bus_i.address[1:0]]
                    ? {1'b0, page_q[bus_i.address[1:0]]} : 8'hFF;
            end else if (lpt_hit) begin
                read_value = lpt_q;
            end else if (nmi_hit) begin
                read_value = nmi_q;
            end
        end
    end

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                page_q[i] <= 7'h00;
            end
            enable_q      <= 4'h0;
            pend_valid_q  <= 1'b0;
            pend_index_q  <= 2'd0;
            pend_page_q   <= 7'h00;
            pend_enable_q <= 1'b0;
            lpt_q         <= 8'hFF;
            nmi_q         <= 8'hFF;
            read_flag_q   <= 1'b0;
            read_data_q   <= 8'h00;
        end else begin
            // EMS entry changes on the edge after the write edge
            if (pend_valid_q) begin
                page_q[pend_index_q]   <= pend_page_q;
                enable_q[pend_index_q] <= pend_enable_q;
            end
            pend_valid_q <= 1'b0;
            if (ems_hit && !bus_i.io_write_n) begin
                pend_index_q <= bus_i.address[1:0];
                if (bus_i.wdata == 8'hFF) begin
                    pend_valid_q  <= 1'b1;
                    pend_page_q   <= 7'h7F;
                    pend_enable_q <= 1'b0;
                end else if (bus_i.wdata < 8'h80) begin
                    pend_valid_q  <= 1'b1;
                    pend_page_q   <= bus_i.wdata[6:0];
                    pend_enable_q <= 1'b1;
                end
            end
            if (lpt_hit && !bus_i.io_write_n) begin
                lpt_q <= bus_i.wdata;
            end
            if (nmi_hit && !bus_i.io_write_n) begin
                nmi_q <= bus_i.wdata;
            end
            read_flag_q <= !bus_i.io_read_n && (ems_hit || lpt_hit || nmi_hit);
            read_data_q <= read_value;
        end
    end

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            compare("chip selects", {3'b000, chip_select_i}, {3'b000, exp_select});
            compare("EMS windows", {4'h0, ems_window_i}, {4'h0, exp_window});
            compare("chipset drive flag", {7'h00, data_from_chipset_i}, {7'h00, read_flag_q});
            compare("read data", data_bus_out_i, read_data_q);
            if (read_flag_q) begin
                reads++;
            end
        end
    end

endmodule

//--- tb/tb_top.sv
// Testbench top for the XT I/O glue block
// Drives random bus cycles from an LFSR after each rising edge and
// leaves the comparing to io_checker

`timescale 1ns/1ps

module tb_top;

    import xt_io_pkg::*;

    localparam logic [15:0] EMS_BASE = 16'h0260;
    localparam logic [15:0] LPT_BASE = 16'h0378;
    localparam int NUM_CYCLES  = 2000;
    localparam int CYCLE_LIMIT = NUM_CYCLES + NUM_CYCLES / 4;

    logic         clock;
    logic         reset;
    io_bus_t      bus;
    logic         tandy_video;
    logic         ems_enabled;
    logic [1:0]   ems_address;
    chip_select_t chip_select;
    logic [3:0]   ems_window;
    logic [7:0]   data_bus_out;
    logic         data_from_chipset;
    int           error_count;
    int           check_count;
    int           read_count;
    int           cycle_count = 0;
    logic [31:0]  lfsr_state = 32'h9962_1bb3;

    xt_io_top #(
        .EMS_IO_BASE (EMS_BASE),
        .LPT_IO_BASE (LPT_BASE)
    ) UUT (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (bus.address),
        .data_i                      (bus.wdata),
        .io_read_n_i                 (bus.io_read_n),
        .io_write_n_i                (bus.io_write_n),
        .memory_read_n_i             (bus.memory_read_n),
        .address_enable_n_i          (bus.address_enable_n),
        .tandy_video_i               (tandy_video),
        .ems_enabled_i               (ems_enabled),
        .ems_address_i               (ems_address),
        .chip_select_o               (chip_select),
        .ems_window_o                (ems_window),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_from_chipset)
    );

    io_checker #(
        .EMS_IO_BASE (EMS_BASE),
        .LPT_IO_BASE (LPT_BASE)
    ) u_checker (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus),
        .tandy_video_i       (tandy_video),
        .ems_enabled_i       (ems_enabled),
        .ems_address_i       (ems_address),
        .chip_select_i       (chip_select),
        .ems_window_i        (ems_window),
        .data_bus_out_i      (data_bus_out),
        .data_from_chipset_i (data_from_chipset),
        .error_count_o       (error_count),
        .check_count_o       (check_count),
        .read_count_o        (read_count)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_idle();
        bus.io_read_n        = 1'b1;
        bus.io_write_n       = 1'b1;
        bus.memory_read_n    = 1'b1;
        bus.address_enable_n = 1'b0;
    endtask

    task automatic drive_cycle();
        logic [31:0] kind;
        logic [31:0] op;
        logic [31:0] aen;
        logic [31:0] rnd;
        logic [31:0] data_sel;
        logic [31:0] data;
        logic [31:0] cfg;
        logic [31:0] seg;
        take_bits(3, kind);
        take_bits(2, op);
        take_bits(3, aen);
        take_bits(20, rnd);
        take_bits(2, data_sel);
        take_bits(8, data);
        take_bits(5, cfg);
        take_bits(2, seg);
        // Mostly page numbers, some disables and some ignored bytes
        case (data_sel[1:0])
            2'd0:    bus.wdata = 8'hFF;
            2'd1:    bus.wdata = data[7:0];
            default: bus.wdata = {1'b0, data[6:0]};
        endcase
        bus.io_read_n        = op[0];
        bus.io_write_n       = (op[1:0] != 2'd1);
        bus.memory_read_n    = 1'b1;
        bus.address_enable_n = (aen[2:0] == 3'd0);
        case (kind[2:0])
            3'd0, 3'd1: bus.address = {rnd[19:10], 2'b00, rnd[7:0]};
            3'd2:       bus.address = {rnd[19:16], EMS_BASE[15:2], rnd[1:0]};
            3'd3:       bus.address = {rnd[19:16], LPT_BASE};
            3'd4:       bus.address = {rnd[19:16], NMI_MASK_BASE[15:3], rnd[2:0]};
            3'd5: begin
                // Memory read in or near an EMS window
                bus.address       = {rnd[19:18] == 2'd0 ? 4'hA : rnd[19:18] == 2'd1 ? 4'hC
                    : rnd[19:18] == 2'd2 ? 4'hD : 4'hE, rnd[15:0]};
                bus.io_read_n     = 1'b1;
                bus.memory_read_n = op[0];
            end
            3'd6:       bus.address = rnd[19:0];
            default: begin
                bus.address = rnd[19:0];
                drive_idle();
            end
        endcase
        if (cfg[4:0] == 5'd0) begin
            tandy_video = !tandy_video;
        end else if (cfg[4:0] == 5'd1) begin
            ems_enabled = !ems_enabled;
        end else if (cfg[4:0] == 5'd2) begin
            ems_address = seg[1:0];
        end
    endtask

    initial begin
        reset       = 1'b1;
        bus         = '0;
        tandy_video = 1'b1;
        ems_enabled = 1'b1;
        ems_address = 2'd0;
        drive_idle();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clock);
            #1;
            drive_cycle();
        end
        @(posedge clock);
        #1;
        drive_idle();
        @(posedge clock);
        @(negedge clock);
        // Let the last comparison of the checker settle first
        #1;
        $display("Checks: %0d, chipset reads: %0d, errors: %0d",
            check_count, read_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/xt_io_pkg.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/io_byte_regs.sv
rtl/read_back_mux.sv
rtl/xt_io_top.sv
tb/io_checker.sv
tb/tb_top.sv

//--- Makefile
LOG = sim.log

all: run

build:
	verilator --binary --timing -f vlog.f --top-module tb_top -o tb_top

run: build
	./obj_dir/tb_top | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only --timing -f vlog.f --top-module tb_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
